// File: flist.f
src/sym_pkg.sv
src/fifo_pkg.sv
src/symbol_mapper.sv
src/fifo_mem.sv
src/fifo_wr_ctrl.sv
src/fifo_rd_ctrl.sv
src/output_fifo.sv
src/tx_symbol_path.sv
verif/tx_symbol_path_assertions.sv
verif/tb_tx_symbol_path.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for the result.

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_tx_symbol_path \
    -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "Test FAILED" "$log"; then
    exit 1
fi
if ! grep -q "Test OK" "$log"; then
    echo "No result line found in $log"
    exit 1
fi
exit 0

// File: src/fifo_mem.sv
`default_nettype none
`timescale 1ns/10ps

module fifo_mem import sym_pkg::*; #(
    parameter  int DEPTH = 16,
    localparam int AW    = $clog2(DEPTH)
) (
    input  wire logic          i_clk,
    input  wire logic          i_we,
    input  wire logic [AW-1:0] i_waddr,
    input  wire logic [AW-1:0] i_raddr,
    input  wire frame_u        i_wdata,
    output frame_u             o_rdata
);

    frame_u mem [DEPTH];

    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // Asynchronous read gives show-ahead data on the read side.
    assign o_rdata = mem[i_raddr];

endmodule

`default_nettype wire

// File: src/fifo_pkg.sv
`default_nettype none

package fifo_pkg;

    // Widest code word the conversion functions handle. Callers zero-extend
    // their pointers into it and truncate the result back.
    localparam int CODE_W = 16;

    typedef logic [CODE_W-1:0] code_t;

    // Read-side flags, registered in the read clock domain.
    typedef struct packed {
        logic empty;
        logic almost_empty;
    } rd_status_t;

    function automatic code_t bin2gray(code_t bin);
        return bin ^ (bin >> 1);
    endfunction

    function automatic code_t gray2bin(code_t gray);
        code_t bin;
        bin[CODE_W-1] = gray[CODE_W-1];
        for (int i = CODE_W - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];    // Running XOR from the top bit down.
        end
        return bin;
    endfunction

endpackage

`default_nettype wire

// File: src/fifo_rd_ctrl.sv
`default_nettype none
`timescale 1ns/10ps

module fifo_rd_ctrl import fifo_pkg::*; #(
    parameter  int DEPTH    = 16,
    parameter  int AE_LEVEL = 2,
    localparam int AW       = $clog2(DEPTH),
    localparam int PW       = AW + 1
) (
    input  wire logic          o_clk,
    input  wire logic          i_rst_n,
    input  wire logic          i_pop_n,
    input  wire logic [PW-1:0] i_wptr_gray,
    output logic      [AW-1:0] o_raddr,
    output logic      [PW-1:0] o_rptr_gray,
    output rd_status_t         o_status
);

    logic [1:0]    rst_sync;
    logic          rst_n;
    logic [PW-1:0] wptr_s1, wptr_s2;
    logic [PW-1:0] wbin_s;
    logic [PW-1:0] rbin, rbin_next, rgray_next;
    logic [PW-1:0] count_next;
    logic          re;

    // *************************************************************************
    // Reset release and write pointer synchronizer.
    // *************************************************************************

    always_ff @(posedge o_clk or negedge i_rst_n) begin
        if (!i_rst_n) rst_sync <= '0;
        else          rst_sync <= {rst_sync[0], 1'b1};
    end
    assign rst_n = rst_sync[1];

    assign wbin_s = PW'(gray2bin(code_t'(wptr_s2)));

    // *************************************************************************
    // Read pointer and flags.
    // *************************************************************************

    assign re         = ~i_pop_n & ~o_status.empty;    // Pops on empty are ignored.
    assign rbin_next  = rbin + PW'(re);
    assign rgray_next = PW'(bin2gray(code_t'(rbin_next)));

    // The synchronized write pointer lags, so this count can only run low.
    assign count_next = wbin_s - rbin_next;

    always_ff @(posedge o_clk or negedge rst_n) begin
        if (!rst_n) begin
            rbin        <= '0;
            o_rptr_gray <= '0;
            wptr_s1     <= '0;
            wptr_s2     <= '0;
            o_status    <= '{empty: 1'b1, almost_empty: 1'b1};
        end else begin
            rbin                  <= rbin_next;
            o_rptr_gray           <= rgray_next;
            wptr_s1               <= i_wptr_gray;
            wptr_s2               <= wptr_s1;
            o_status.empty        <= (rgray_next == wptr_s2);
            o_status.almost_empty <= (count_next <= PW'(AE_LEVEL));
        end
    end

    // Address follows the pointer, so new data shows in the cycle of the pop.
    assign o_raddr = rbin[AW-1:0];

endmodule

`default_nettype wire

// File: src/fifo_wr_ctrl.sv
`default_nettype none
`timescale 1ns/10ps

module fifo_wr_ctrl import fifo_pkg::*; #(
    parameter  int DEPTH = 16,
    localparam int AW    = $clog2(DEPTH),
    localparam int PW    = AW + 1
) (
    input  wire logic          i_clk,
    input  wire logic          i_rst_n,
    input  wire logic          i_push_n,
    input  wire logic [PW-1:0] i_rptr_gray,
    output logic      [AW-1:0] o_waddr,
    output logic               o_we,
    output logic      [PW-1:0] o_wptr_gray,
    output logic               o_full
);

    logic [1:0]    rst_sync;
    logic          rst_n;
    logic [PW-1:0] rptr_s1, rptr_s2;
    logic [PW-1:0] wbin, wbin_next, wgray_next;

    // Reset asserts at once and releases on i_clk.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) rst_sync <= '0;
        else          rst_sync <= {rst_sync[0], 1'b1};
    end
    assign rst_n = rst_sync[1];

    assign o_we       = ~i_push_n & ~o_full;   // A push while full is dropped.
    assign wbin_next  = wbin + PW'(o_we);
    assign wgray_next = PW'(bin2gray(code_t'(wbin_next)));

    always_ff @(posedge i_clk or negedge rst_n) begin
        if (!rst_n) begin
            wbin        <= '0;
            o_wptr_gray <= '0;
            rptr_s1     <= '0;
            rptr_s2     <= '0;
            o_full      <= 1'b0;
        end else begin
            wbin        <= wbin_next;
            o_wptr_gray <= wgray_next;
            rptr_s1     <= i_rptr_gray;
            rptr_s2     <= rptr_s1;
            // Full when the writer is one lap ahead of the synchronized reader.
            o_full      <= (wgray_next == {~rptr_s2[PW-1:PW-2], rptr_s2[PW-3:0]});
        end
    end

    assign o_waddr = wbin[AW-1:0];

endmodule

`default_nettype wire

// File: src/output_fifo.sv
`default_nettype none
`timescale 1ns/10ps

module output_fifo import sym_pkg::*, fifo_pkg::*; #(
    parameter  int DEPTH    = 16,
    parameter  int AE_LEVEL = 2,
    localparam int AW       = $clog2(DEPTH),
    localparam int PW       = AW + 1
) (
    input  wire logic   i_clk,
    input  wire logic   o_clk,
    input  wire logic   i_rst_n,
    input  wire logic   i_push_n,
    input  wire frame_u i_frame,
    input  wire logic   i_pop_n,
    output frame_u      o_frame,
    output rd_status_t  o_status,
    output logic        o_full
);

    logic          we;
    logic [AW-1:0] waddr, raddr;
    logic [PW-1:0] wptr_gray;   // Write domain to read domain.
    logic [PW-1:0] rptr_gray;   // Read domain to write domain.

    fifo_mem #(
        .DEPTH    (DEPTH)
    ) u_mem (
        .i_clk    (i_clk),
        .i_we     (we),
        .i_waddr  (waddr),
        .i_raddr  (raddr),
        .i_wdata  (i_frame),
        .o_rdata  (o_frame)
    );

    fifo_wr_ctrl #(
        .DEPTH       (DEPTH)
    ) u_wr_ctrl (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_push_n    (i_push_n),
        .i_rptr_gray (rptr_gray),
        .o_waddr     (waddr),
        .o_we        (we),
        .o_wptr_gray (wptr_gray),
        .o_full      (o_full)
    );

    fifo_rd_ctrl #(
        .DEPTH       (DEPTH),
        .AE_LEVEL    (AE_LEVEL)
    ) u_rd_ctrl (
        .o_clk       (o_clk),
        .i_rst_n     (i_rst_n),
        .i_pop_n     (i_pop_n),
        .i_wptr_gray (wptr_gray),
        .o_raddr     (raddr),
        .o_rptr_gray (rptr_gray),
        .o_status    (o_status)
    );

endmodule

`default_nettype wire

// File: src/sym_pkg.sv
`default_nettype none

package sym_pkg;

    // *************************************************************************
    // Link geometry.
    // *************************************************************************

    localparam int NUM_CH  = 8;               // Channels per frame.
    localparam int SYM_W   = 3;               // PAM-8 symbol width.
    localparam int FRAME_W = NUM_CH * SYM_W;

    // One PAM-8 level, -4 to 3.
    typedef logic signed [SYM_W-1:0] sym_t;

    // The same 24 bits seen as a flat memory word or as per-channel symbols.
    // Channel 0 sits in the low bits.
    typedef union packed {
        logic [FRAME_W-1:0]      raw;
        sym_t [NUM_CH-1:0]       sym;
    } frame_u;

endpackage

`default_nettype wire

// File: src/symbol_mapper.sv
`default_nettype none
`timescale 1ns/10ps

module symbol_mapper import sym_pkg::*, fifo_pkg::*; (
    input  wire logic               i_clk,
    input  wire logic               i_rst_n,
    input  wire logic               i_valid,
    input  wire logic [FRAME_W-1:0] i_bits,
    output logic                    o_push_n,
    output frame_u                  o_frame
);

    frame_u frame_d;

    // Each 3-bit group is a Gray code. Its binary index is offset by half the
    // range to give a signed level.
    always_comb begin
        logic [SYM_W-1:0] idx;
        frame_d = '0;
        for (int c = 0; c < NUM_CH; c++) begin
            idx = SYM_W'(gray2bin(code_t'(i_bits[SYM_W*c +: SYM_W])));
            // Flipping the MSB subtracts 4 in three-bit two's complement.
            frame_d.sym[c] = sym_t'({~idx[SYM_W-1], idx[SYM_W-2:0]});
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_push_n <= 1'b1;
        end else begin
            o_push_n <= ~i_valid;           // Push is active low.
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_frame <= frame_d;
        end
    end

endmodule

`default_nettype wire

// File: src/tx_symbol_path.sv
`default_nettype none
`timescale 1ns/10ps

module tx_symbol_path import sym_pkg::*, fifo_pkg::*; #(
    parameter int DEPTH    = 16,    // Power of two, at least 4.
    parameter int AE_LEVEL = 2
) (
    input  wire logic               i_clk,
    input  wire logic               o_clk,
    input  wire logic               i_rst_n,
    input  wire logic               i_valid,
    input  wire logic [FRAME_W-1:0] i_bits,
    input  wire logic               i_pop_n,
    output frame_u                  o_frame,
    output rd_status_t              o_status,
    output logic                    o_full
);

    logic   push_n;
    frame_u map_frame;

    symbol_mapper u_mapper (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_valid  (i_valid),
        .i_bits   (i_bits),
        .o_push_n (push_n),
        .o_frame  (map_frame)
    );

    output_fifo #(
        .DEPTH    (DEPTH),
        .AE_LEVEL (AE_LEVEL)
    ) u_fifo (
        .i_clk    (i_clk),
        .o_clk    (o_clk),
        .i_rst_n  (i_rst_n),
        .i_push_n (push_n),
        .i_frame  (map_frame),
        .i_pop_n  (i_pop_n),
        .o_frame  (o_frame),
        .o_status (o_status),
        .o_full   (o_full)
    );

endmodule

`default_nettype wire

// File: verif/tb_tx_symbol_path.sv
`default_nettype none
`timescale 1ns/10ps

module tb_tx_symbol_path import sym_pkg::*, fifo_pkg::*; ();

    localparam int RESET_CYCLES = 5;
    // Rough i_clk budget of each test in run order, then a margin.
    localparam int MAX_CYCLES   = RESET_CYCLES + 10 + 30 + 60 + 90 + 60 + 30 + 200;

    logic               i_clk = 1'b0;
    logic               o_clk = 1'b0;
    logic               i_rst_n, i_valid, i_pop_n;
    logic [FRAME_W-1:0] i_bits;
    frame_u             o_frame;
    rd_status_t         o_status;
    logic               o_full;

    logic [31:0] lfsr;
    frame_u      exp_q[$];          // Mapped frames in write order.
    int          errors = 0, checks = 0, tests = 0, cycles = 0;

    tx_symbol_path #(
        .DEPTH    (16),
        .AE_LEVEL (2)
    ) u_dut (.*);

    always #5 i_clk = ~i_clk;

    always begin
        #3;                         // Read clock lags by 3 ns.
        forever #5 o_clk = ~o_clk;
    end

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("error: run stopped after %0d cycles, a test never completed", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    // *************************************************************************
    // Stimulus and reference model.
    // *************************************************************************

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [FRAME_W-1:0] random_word();
        logic [FRAME_W-1:0] w;
        for (int i = 0; i < FRAME_W; i++) begin
            lfsr = lfsr_next(lfsr);
            w[i] = lfsr[0];
        end
        return w;
    endfunction

    // Gray code to binary index, then offset by -4.
    function automatic frame_u map_word(logic [FRAME_W-1:0] bits);
        frame_u     f;
        logic [2:0] g;
        int         b;
        f = '0;
        for (int c = 0; c < NUM_CH; c++) begin
            g = bits[SYM_W*c +: SYM_W];
            b = (g[2] ? 4 : 0) + ((g[2] ^ g[1]) ? 2 : 0) + ((g[2] ^ g[1] ^ g[0]) ? 1 : 0);
            f.sym[c] = sym_t'(b - 4);
        end
        return f;
    endfunction

    function automatic rd_status_t make_status(logic empty, logic almost_empty);
        rd_status_t s;
        s.empty        = empty;
        s.almost_empty = almost_empty;
        return s;
    endfunction

    // *************************************************************************
    // Compare tasks.
    // *************************************************************************

    task automatic check_frame(input frame_u got, input frame_u exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: o_frame got %h expected %h", $time, got.raw, exp.raw);
            for (int c = 0; c < NUM_CH; c++) begin
                if (got.sym[c] !== exp.sym[c]) begin
                    $display("  channel %0d symbol got %0d expected %0d", c, got.sym[c], exp.sym[c]);
                end
            end
        end
    endtask

    task automatic check_status(input rd_status_t got, input rd_status_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: o_status got empty=%b almost_empty=%b expected %b %b",
                     $time, got.empty, got.almost_empty, exp.empty, exp.almost_empty);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // Caller is 1 ns past an i_clk edge. The word enters the mapper on the next edge.
    task automatic drive_word(input logic [FRAME_W-1:0] w);
        i_valid = 1'b1;
        i_bits  = w;
        @(posedge i_clk);
        #1;
        i_valid = 1'b0;
    endtask

    task automatic push_words(input int n);
        logic [FRAME_W-1:0] w;
        @(posedge i_clk);
        #1;
        for (int k = 0; k < n; k++) begin
            w = random_word();
            exp_q.push_back(map_word(w));
            drive_word(w);
        end
    endtask

    task automatic pop_expect(input frame_u exp);
        @(posedge o_clk);
        #1;
        while (o_status.empty) begin
            @(posedge o_clk);
            #1;
        end
        check_frame(o_frame, exp);
        i_pop_n = 1'b0;
        @(posedge o_clk);
        #1;
        i_pop_n = 1'b1;
    endtask

    task automatic pop_queue();
        while (exp_q.size() > 0) begin
            pop_expect(exp_q.pop_front());
        end
        repeat (6) @(posedge o_clk);
        #1;
        check_status(o_status, make_status(1'b1, 1'b1));
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    // *************************************************************************
    // Directed tests.
    // *************************************************************************

    task automatic test_reset_state();
        int e;
        e = errors;
        check_status(o_status, make_status(1'b1, 1'b1));
        check_bit("o_full", o_full, 1'b0);
        report_test("reset_state", e);
    endtask

    task automatic test_mapping();
        int                 e;
        logic [FRAME_W-1:0] w;
        frame_u             exp;
        int                 levels [NUM_CH] = '{-4, -3, -1, -2, 3, 2, 0, 1};
        e = errors;
        for (int c = 0; c < NUM_CH; c++) begin
            w[SYM_W*c +: SYM_W] = SYM_W'(c);   // Gray code c on channel c.
            exp.sym[c]          = sym_t'(levels[c]);
        end
        @(posedge i_clk);
        #1;
        drive_word(w);
        exp_q.push_back(exp);
        pop_queue();
        report_test("mapping", e);
    endtask

    task automatic test_ordering();
        int e;
        e = errors;
        push_words(12);
        pop_queue();
        report_test("ordering", e);
    endtask

    task automatic test_full_drop();
        int e;
        e = errors;
        push_words(19);
        check_bit("o_full", o_full, 1'b1);
        repeat (3) void'(exp_q.pop_back());    // The last three words find the FIFO full.
        pop_queue();
        check_bit("o_full", o_full, 1'b0);
        report_test("full_drop", e);
    endtask

    task automatic test_almost_empty();
        int e;
        e = errors;
        push_words(2);
        repeat (10) @(posedge o_clk);
        #1;
        check_status(o_status, make_status(1'b0, 1'b1));
        push_words(1);
        repeat (10) @(posedge o_clk);
        #1;
        check_status(o_status, make_status(1'b0, 1'b0));
        pop_queue();
        report_test("almost_empty", e);
    endtask

    task automatic test_pop_on_empty();
        int e;
        e = errors;
        @(posedge o_clk);
        #1;
        i_pop_n = 1'b0;
        repeat (5) @(posedge o_clk);
        #1;
        i_pop_n = 1'b1;
        check_status(o_status, make_status(1'b1, 1'b1));
        push_words(1);
        pop_queue();
        report_test("pop_on_empty", e);
    endtask

    initial begin
        i_rst_n = 1'b0;
        i_valid = 1'b0;
        i_bits  = '0;
        i_pop_n = 1'b1;
        lfsr    = 32'd72042;
        repeat (RESET_CYCLES) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;
        repeat (3) @(posedge o_clk);    // Both reset synchronizers release.
        #1;
        test_reset_state();
        test_mapping();
        test_ordering();
        test_full_drop();
        test_almost_empty();
        test_pop_on_empty();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/tx_symbol_path_assertions.sv
`default_nettype none
`timescale 1ns/10ps

module tx_symbol_path_assertions import fifo_pkg::*; #(
    parameter int PW = 5
) (
    input wire logic          i_clk,
    input wire logic          i_rd_clk,
    input wire logic          i_rst_n,
    input wire logic          i_push_n,
    input wire logic          i_pop_n,
    input wire logic          i_full,
    input wire rd_status_t    i_status,
    input wire logic [PW-1:0] i_wptr_gray,
    input wire logic [PW-1:0] i_rptr_gray
);

    empty_has_ae: assert property (@(posedge i_rd_clk) disable iff (!i_rst_n)
        i_status.empty |-> i_status.almost_empty)
        else $error("empty flag set without almost_empty");

    // A dropped push must leave the write pointer where it was.
    full_holds_wptr: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (!i_push_n && i_full) |=> $stable(i_wptr_gray))
        else $error("write pointer moved on a push while full");

    empty_holds_rptr: assert property (@(posedge i_rd_clk) disable iff (!i_rst_n)
        (!i_pop_n && i_status.empty) |=> $stable(i_rptr_gray))
        else $error("read pointer moved on a pop while empty");

    push_known: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !$isunknown(i_push_n))
        else $error("push strobe is unknown");

    pop_known: assert property (@(posedge i_rd_clk) disable iff (!i_rst_n)
        !$isunknown(i_pop_n))
        else $error("pop strobe is unknown");

endmodule

bind output_fifo tx_symbol_path_assertions #(
    .PW          (PW)
) u_assertions (
    .i_clk       (i_clk),
    .i_rd_clk    (o_clk),
    .i_rst_n     (i_rst_n),
    .i_push_n    (i_push_n),
    .i_pop_n     (i_pop_n),
    .i_full      (o_full),
    .i_status    (o_status),
    .i_wptr_gray (wptr_gray),
    .i_rptr_gray (rptr_gray)
);

`default_nettype wire
